//--- design/mem_pkg.sv
// Shared definitions for the word memory and block-move engine
// Word and lane widths, move mode codes and the memory word type

package mem_pkg;

  // Word geometry
  localparam int DATA_W    = 32;
  localparam int NUM_BYTES = DATA_W / 8; // Byte lanes, also the mask width

  // Values of the mode input
  localparam logic MODE_FILL = 1'b0; // Write pattern over the region
  localparam logic MODE_COPY = 1'b1; // Copy source region to destination

  // One memory word, seen whole or lane by lane
  typedef union packed {
    logic [DATA_W-1:0]         word;  // Whole-word view
    logic [NUM_BYTES-1:0][7:0] bytes; // Lane view, lane 0 is bits 7:0
  } mem_word_u;

endpackage

//--- design/dp_ram_wbe.sv
// True dual-port RAM with synchronous read and per-byte write enables
// Each enabled port writes its masked lanes and returns the old word
// one clock later (read-before-write). Contents start at zero.

module dp_ram_wbe #(
  parameter int ADDR_W = 6
) (
  input  logic                          clk,
  input  logic                          en_a,
  input  logic                          en_b,
  input  logic [mem_pkg::NUM_BYTES-1:0] wbe_a,
  input  logic [mem_pkg::NUM_BYTES-1:0] wbe_b,
  input  logic [ADDR_W-1:0]             addr_a,
  input  logic [ADDR_W-1:0]             addr_b,
  input  mem_pkg::mem_word_u            wdata_a,
  input  mem_pkg::mem_word_u            wdata_b,
  output mem_pkg::mem_word_u            rdata_a,
  output mem_pkg::mem_word_u            rdata_b
);
  import mem_pkg::*;

  localparam int DEPTH = 1 << ADDR_W;

  mem_word_u mem [DEPTH]; // Block-style storage array

  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = '0; // Power-up contents
    end
  end

  // Port A, host side
  always @(posedge clk) begin
    if (en_a) begin
      for (int i = 0; i < NUM_BYTES; i++) begin
        if (wbe_a[i]) begin
          mem[addr_a].bytes[i] <= wdata_a.bytes[i];
        end
      end
      rdata_a <= mem[addr_a]; // Old word
    end
  end

  // Port B, engine side
  always @(posedge clk) begin
    if (en_b) begin
      for (int i = 0; i < NUM_BYTES; i++) begin
        if (wbe_b[i]) begin
          mem[addr_b].bytes[i] <= wdata_b.bytes[i];
        end
      end
      rdata_b <= mem[addr_b]; // Old word
    end
  end

  // A lane may only be written through an enabled port
  a_wbe_needs_en_a: assert property (@(posedge clk) !en_a |-> (wbe_a == '0))
    else $error("port A byte enable set while port disabled");
  a_wbe_needs_en_b: assert property (@(posedge clk) !en_b |-> (wbe_b == '0))
    else $error("port B byte enable set while port disabled");

  a_wbe_known_a: assert property (@(posedge clk) en_a |-> !$isunknown(wbe_a))
    else $error("port A byte mask unknown while enabled");
  a_wbe_known_b: assert property (@(posedge clk) en_b |-> !$isunknown(wbe_b))
    else $error("port B byte mask unknown while enabled");

endmodule

//--- design/word_counter.sv
// Address and length counter for the block-move engine
// Holds the running source and destination addresses and the words left

module word_counter #(
  parameter int ADDR_W = 6
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              load,
  input  logic              step,
  input  logic [ADDR_W-1:0] src_base,
  input  logic [ADDR_W-1:0] dst_base,
  input  logic [ADDR_W:0]   length,
  output logic [ADDR_W-1:0] src_addr,
  output logic [ADDR_W-1:0] dst_addr,
  output logic              last,
  output logic              empty
);

  logic [ADDR_W:0] remain_q; // Words still to move

  always_ff @(posedge clk) begin
    if (rst) begin
      src_addr <= '0;
      dst_addr <= '0;
      remain_q <= '0;
    end else if (load) begin
      src_addr <= src_base;
      dst_addr <= dst_base;
      remain_q <= length;
    end else if (step) begin
      src_addr <= src_addr + 1'b1; // Wraps modulo depth
      dst_addr <= dst_addr + 1'b1;
      remain_q <= remain_q - 1'b1;
    end
  end

  assign last  = (remain_q == {{ADDR_W{1'b0}}, 1'b1});
  assign empty = (remain_q == '0);

  // The FSM must stop stepping once the region is exhausted
  a_no_step_when_empty: assert property (
    @(posedge clk) disable iff (rst) step |-> !empty
  ) else $error("counter stepped with no words remaining");

endmodule

//--- design/move_fsm.sv
// Sequencer for the block-move engine
// Runs fill and copy operations on RAM port B and steps the word counter.
// A check cycle after start decides between fill, copy and zero length.

module move_fsm #(
  parameter int ADDR_W = 6
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          start,
  input  logic                          mode,
  input  mem_pkg::mem_word_u            pattern,
  input  logic [ADDR_W-1:0]             src_addr,
  input  logic [ADDR_W-1:0]             dst_addr,
  input  logic                          last,
  input  logic                          empty,
  input  mem_pkg::mem_word_u            rdata_b,
  output logic                          load,
  output logic                          step,
  output logic                          en_b,
  output logic [mem_pkg::NUM_BYTES-1:0] wbe_b,
  output logic [ADDR_W-1:0]             addr_b,
  output mem_pkg::mem_word_u            wdata_b,
  output logic                          busy,
  output logic                          done
);
  import mem_pkg::*;

  localparam logic [2:0] S_IDLE       = 3'd0;
  localparam logic [2:0] S_CHECK      = 3'd1;
  localparam logic [2:0] S_FILL       = 3'd2;
  localparam logic [2:0] S_COPY_READ  = 3'd3;
  localparam logic [2:0] S_COPY_WRITE = 3'd4;
  localparam logic [2:0] S_FINISH     = 3'd5;

  logic [2:0] state_q;
  logic [2:0] state_d;
  logic       mode_q;    // Mode captured at start
  mem_word_u  pattern_q; // Fill word captured at start

  // Start is only honoured in idle
  assign load = (state_q == S_IDLE) && start;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= S_IDLE;
      mode_q  <= MODE_FILL;
      busy    <= 1'b0;
      done    <= 1'b0;
    end else begin
      state_q <= state_d;
      done    <= (state_d == S_FINISH); // Pulse after the last write
      if (load) begin
        mode_q <= mode;
        busy   <= 1'b1; // Set from the accepted start
      end else if (state_d == S_FINISH) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      pattern_q <= pattern;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE:       if (start) state_d = S_CHECK;
      S_CHECK: begin
        if (empty) begin
          state_d = S_FINISH; // Zero length, nothing to write
        end else if (mode_q == MODE_FILL) begin
          state_d = S_FILL;
        end else begin
          state_d = S_COPY_READ;
        end
      end
      S_FILL:       if (last) state_d = S_FINISH;
      S_COPY_READ:  state_d = S_COPY_WRITE;
      S_COPY_WRITE: state_d = last ? S_FINISH : S_COPY_READ;
      S_FINISH:     state_d = S_IDLE;
      default:      state_d = S_IDLE;
    endcase
  end

  // Port B drive, decoded from the current state
  always_comb begin
    en_b   = 1'b0;
    wbe_b  = '0;
    step   = 1'b0;
    addr_b = dst_addr;
    case (state_q)
      S_FILL, S_COPY_WRITE: begin
        en_b  = 1'b1;
        wbe_b = '1; // Full-word write
        step  = 1'b1;
      end
      S_COPY_READ: begin
        en_b   = 1'b1;
        addr_b = src_addr;
      end
      default: ;
    endcase
    // Copy writes back the word fetched in the previous cycle
    wdata_b.word = (mode_q == MODE_COPY) ? rdata_b.word : pattern_q.word;
  end

  a_busy_done_excl: assert property (@(posedge clk) disable iff (rst) !(busy && done))
    else $error("busy and done high together");
  a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else $error("done held for more than one cycle");

endmodule

//--- design/mem_move_top.sv
// Word memory with a block-move engine
// Host owns RAM port A; the fill/copy engine owns port B.
// Joins the RAM, the word counter and the sequencer.

module mem_move_top #(
  parameter int ADDR_W = 6
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          host_en,
  input  logic [mem_pkg::NUM_BYTES-1:0] host_wbe,
  input  logic [ADDR_W-1:0]             host_addr,
  input  logic [mem_pkg::DATA_W-1:0]    host_wdata,
  output logic [mem_pkg::DATA_W-1:0]    host_rdata,
  input  logic                          start,
  input  logic                          mode,
  input  logic [ADDR_W-1:0]             src_base,
  input  logic [ADDR_W-1:0]             dst_base,
  input  logic [ADDR_W:0]               length,
  input  logic [mem_pkg::DATA_W-1:0]    pattern,
  output logic                          busy,
  output logic                          done
);
  import mem_pkg::*;

  // Engine to RAM port B
  logic                 en_b;
  logic [NUM_BYTES-1:0] wbe_b;
  logic [ADDR_W-1:0]    addr_b;
  mem_word_u            wdata_b;
  mem_word_u            rdata_b;

  // FSM to counter
  logic              load;
  logic              step;
  logic [ADDR_W-1:0] src_addr;
  logic [ADDR_W-1:0] dst_addr;
  logic              last;
  logic              empty;

  dp_ram_wbe #(.ADDR_W(ADDR_W)) i_ram (
    .clk     (clk),
    .en_a    (host_en),
    .en_b    (en_b),
    .wbe_a   (host_wbe),
    .wbe_b   (wbe_b),
    .addr_a  (host_addr),
    .addr_b  (addr_b),
    .wdata_a (host_wdata),
    .wdata_b (wdata_b),
    .rdata_a (host_rdata),
    .rdata_b (rdata_b)
  );

  word_counter #(.ADDR_W(ADDR_W)) i_counter (
    .clk      (clk),
    .rst      (rst),
    .load     (load),
    .step     (step),
    .src_base (src_base),
    .dst_base (dst_base),
    .length   (length),
    .src_addr (src_addr),
    .dst_addr (dst_addr),
    .last     (last),
    .empty    (empty)
  );

  move_fsm #(.ADDR_W(ADDR_W)) i_fsm (
    .clk      (clk),
    .rst      (rst),
    .start    (start),
    .mode     (mode),
    .pattern  (pattern),
    .src_addr (src_addr),
    .dst_addr (dst_addr),
    .last     (last),
    .empty    (empty),
    .rdata_b  (rdata_b),
    .load     (load),
    .step     (step),
    .en_b     (en_b),
    .wbe_b    (wbe_b),
    .addr_b   (addr_b),
    .wdata_b  (wdata_b),
    .busy     (busy),
    .done     (done)
  );

endmodule

//--- sim/tb_mem_move.sv
// Testbench for the word memory with block-move engine
// Drives host byte writes, fill, copy, zero-length and ignored-start cases.
// A reference memory model supplies expected host reads; concurrent
// assertions check read data and the busy/done timing.

module tb_mem_move;
  timeunit 1ns;
  timeprecision 1ps;
  import mem_pkg::*;

  localparam int ADDR_W      = 6;
  localparam int DEPTH       = 1 << ADDR_W;
  localparam int NUM_WRITES  = 24;
  localparam int MAX_LEN     = 16;
  localparam int NUM_MOVES   = 4;
  localparam int NUM_SWEEPS  = 5;
  localparam int HOST_OPS    = NUM_WRITES + MAX_LEN + NUM_SWEEPS * DEPTH;
  localparam int CYCLE_LIMIT = NUM_MOVES * (2 * MAX_LEN + 2) + HOST_OPS + 200;
  localparam int MOVE_WAIT   = 2 * MAX_LEN + 4; // Per-move wait for done

  logic                 clk;
  logic                 rst;
  logic                 host_en;
  logic [NUM_BYTES-1:0] host_wbe;
  logic [ADDR_W-1:0]    host_addr;
  logic [DATA_W-1:0]    host_wdata;
  logic [DATA_W-1:0]    host_rdata;
  logic                 start;
  logic                 mode;
  logic [ADDR_W-1:0]    src_base;
  logic [ADDR_W-1:0]    dst_base;
  logic [ADDR_W:0]      length;
  logic [DATA_W-1:0]    pattern;
  logic                 busy;
  logic                 done;

  int seed      = 32'h8a4f;
  int errors    = 0;
  int reads     = 0;
  int cyc       = 0;            // Index of the next rising edge
  int busy_from = 32'h7fffffff; // First edge with busy expected
  int done_at   = 32'h7fffffff; // Edge with done expected

  logic              rd_chk   = 1'b0;
  logic [DATA_W-1:0] rd_exp   = '0;
  logic [DATA_W-1:0] rd_exp_q = '0;
  logic [DATA_W-1:0] model [DEPTH]; // Reference memory

  mem_move_top #(.ADDR_W(ADDR_W)) i_dut (
    .clk        (clk),
    .rst        (rst),
    .host_en    (host_en),
    .host_wbe   (host_wbe),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_rdata (host_rdata),
    .start      (start),
    .mode       (mode),
    .src_base   (src_base),
    .dst_base   (dst_base),
    .length     (length),
    .pattern    (pattern),
    .busy       (busy),
    .done       (done)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc      <= cyc + 1;
    rd_exp_q <= rd_exp; // Expected word for the next edge
  end

  a_host_read: assert property (@(posedge clk) disable iff (rst)
    rd_chk |=> (host_rdata == rd_exp_q)
  ) else begin
    errors++;
    $display("mismatch at %0t: host read returned %h, expected %h",
             $time, $sampled(host_rdata), $sampled(rd_exp_q));
  end

  a_busy_window: assert property (@(posedge clk) disable iff (rst)
    busy == (cyc >= busy_from && cyc < done_at)
  ) else begin
    errors++;
    $display("mismatch at %0t: busy is %b outside its expected window",
             $time, $sampled(busy));
  end

  a_done_time: assert property (@(posedge clk) disable iff (rst)
    done == (cyc == done_at)
  ) else begin
    errors++;
    $display("mismatch at %0t: done is %b, expected at edge %0d",
             $time, $sampled(done), $sampled(done_at));
  end

  // Byte-mask rule shared by host and engine writes
  function automatic logic [DATA_W-1:0] merge_lanes(input logic [DATA_W-1:0] old_w,
                                                    input logic [DATA_W-1:0] new_w,
                                                    input logic [NUM_BYTES-1:0] mask);
    logic [DATA_W-1:0] res;
    res = old_w;
    for (int b = 0; b < NUM_BYTES; b++) begin
      if (mask[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  task automatic host_access(input logic [ADDR_W-1:0] addr,
                             input logic [NUM_BYTES-1:0] wbe,
                             input logic [DATA_W-1:0] wdata);
    @(negedge clk);
    host_en    = 1'b1;
    host_addr  = addr;
    host_wbe   = wbe;
    host_wdata = wdata;
    rd_chk     = 1'b1;
    rd_exp     = model[addr]; // Read-before-write gives the old word
    model[addr] = merge_lanes(model[addr], wdata, wbe);
    reads++;
  endtask

  task automatic host_release;
    @(negedge clk);
    host_en  = 1'b0;
    host_wbe = '0;
    rd_chk   = 1'b0;
  endtask

  task automatic sweep_memory;
    for (int a = 0; a < DEPTH; a++) begin
      host_access(ADDR_W'(a), '0, '0);
    end
    host_release();
  endtask

  // Start one move, update the model and wait for done
  task automatic run_move(input logic m, input logic [ADDR_W-1:0] src,
                          input logic [ADDR_W-1:0] dst, input logic [ADDR_W:0] n,
                          input logic [DATA_W-1:0] pat, input int poke);
    logic [ADDR_W-1:0] s;
    logic [ADDR_W-1:0] d;
    int waited;
    @(negedge clk);
    start     = 1'b1;
    mode      = m;
    src_base  = src;
    dst_base  = dst;
    length    = n;
    pattern   = pat;
    busy_from = cyc + 1;
    done_at   = (m == MODE_COPY) ? cyc + 2 * n + 2 : cyc + n + 2;
    for (int i = 0; i < n; i++) begin
      s = src + ADDR_W'(i); // Addresses wrap modulo depth
      d = dst + ADDR_W'(i);
      if (m == MODE_COPY) model[d] = merge_lanes(model[d], model[s], '1);
      else model[d] = merge_lanes(model[d], pat, '1);
    end
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
      start = (waited == poke); // Stray start while busy
      if (start) begin
        mode    = MODE_COPY;
        length  = 3;
        pattern = ~pat;
      end
    end while (!done && waited < MOVE_WAIT);
    start = 1'b0;
    if (!done) begin
      errors++;
      $display("The engine gave no done pulse within %0d cycles of start", MOVE_WAIT);
    end
  endtask

  initial begin
    wait (cyc >= CYCLE_LIMIT);
    $display("The run was stopped at the cycle limit of %0d cycles", CYCLE_LIMIT);
    $display("%0d errors in %0d host reads", errors, reads);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    logic [ADDR_W:0]   len;
    logic [ADDR_W-1:0] base;
    rst        = 1'b1;
    host_en    = 1'b0;
    host_wbe   = '0;
    host_addr  = '0;
    host_wdata = '0;
    start      = 1'b0;
    mode       = MODE_FILL;
    src_base   = '0;
    dst_base   = '0;
    length     = '0;
    pattern    = '0;
    for (int a = 0; a < DEPTH; a++) begin
      model[a] = '0; // RAM powers up cleared
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    repeat (5) @(negedge clk); // Idle, busy and done must stay low

    for (int i = 0; i < NUM_WRITES; i++) begin
      host_access(ADDR_W'($random(seed)), NUM_BYTES'($random(seed)), $random(seed));
    end
    host_release();
    sweep_memory();

    len  = 1 + $unsigned($random(seed)) % MAX_LEN;
    base = ADDR_W'($random(seed));
    run_move(MODE_FILL, '0, base, len, $random(seed), 0);
    sweep_memory();

    // Seed the copy source, destination half a memory away
    len  = 1 + $unsigned($random(seed)) % MAX_LEN;
    base = ADDR_W'($random(seed));
    for (int i = 0; i < len; i++) begin
      host_access(base + ADDR_W'(i), '1, $random(seed));
    end
    host_release();
    run_move(MODE_COPY, base, base + ADDR_W'(DEPTH / 2), len, '0, 0);
    sweep_memory();

    run_move(MODE_FILL, '0, ADDR_W'($random(seed)), '0, $random(seed), 0);
    sweep_memory();

    len = 4 + $unsigned($random(seed)) % (MAX_LEN - 3);
    run_move(MODE_FILL, '0, ADDR_W'($random(seed)), len, $random(seed), 2);
    sweep_memory();

    repeat (2) @(negedge clk); // Let the last read check complete
    $display("%0d errors in %0d host reads", errors, reads);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- compile.f
design/mem_pkg.sv
design/dp_ram_wbe.sv
design/word_counter.sv
design/move_fsm.sv
design/mem_move_top.sv
sim/tb_mem_move.sv

//--- Bender.yml
package:
  name: mem_move

sources:
  # Package first, then leaf modules, then the top level
  - files:
      - design/mem_pkg.sv
      - design/dp_ram_wbe.sv
      - design/word_counter.sv
      - design/move_fsm.sv
      - design/mem_move_top.sv

  - target: simulation
    files:
      - sim/tb_mem_move.sv
